// ==== common/smartnic_app_pkg.sv ====
package smartnic_app_pkg;

    // ==============================
    // datapath widths
    // ==============================
    // one bus word
    localparam int DATA_W = 64;
    // port code
    localparam int PORT_W = 2;
    // vf index within one pf
    localparam int VF_W   = 2;
    // rss entropy, i.e. queue id
    localparam int QID_W  = 12;

    // port and table counts
    localparam int NUM_PORTS = 4;
    localparam int NUM_HOST  = 2;
    localparam int NUM_VF    = 4;

    // ==============================
    // port codes
    // ==============================
    // line side
    localparam logic [PORT_W-1:0] PORT_CMAC0 = 2'd0;
    localparam logic [PORT_W-1:0] PORT_CMAC1 = 2'd1;
    // host side, pf = code - 2
    localparam logic [PORT_W-1:0] PORT_HOST0 = 2'd2;
    localparam logic [PORT_W-1:0] PORT_HOST1 = 2'd3;

    // ==============================
    // register map
    // ==============================
    localparam int ADDR_W = 8;
    localparam int REG_W  = 16;

    // forwarding entries 0x00..0x03, one per ingress port
    localparam logic [ADDR_W-1:0] ADDR_FWD_BASE  = 8'h00;
    // host demux select, bit n for host n
    localparam logic [ADDR_W-1:0] ADDR_DEMUX_SEL = 8'h10;
    // hash2qid blocks, 16 addresses each
    localparam logic [ADDR_W-1:0] ADDR_H2Q0_BASE = 8'h20;
    localparam logic [ADDR_W-1:0] ADDR_H2Q1_BASE = 8'h30;

    // offsets inside a hash2qid block
    localparam int                  H2Q_OFS_W        = 4;
    localparam logic [H2Q_OFS_W-1:0] H2Q_Q_CONFIG_OFS = 4'd0;
    localparam logic [H2Q_OFS_W-1:0] H2Q_VF_TABLE_OFS = 4'd1;

endpackage

// ==== src/p4_lookup.sv ====
`timescale 1ns/1ps

module p4_lookup import smartnic_app_pkg::*; (
    input  logic              tb,
    input  logic              arst_n,
    // config write strobe
    input  logic              reg_wr,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic [REG_W-1:0]  reg_wdata,
    // ingress words
    input  logic              in_valid,
    input  logic              in_sop,
    input  logic              in_eop,
    input  logic [PORT_W-1:0] in_port,
    input  logic [DATA_W-1:0] in_data,
    // stage 1 out
    output logic              s1_valid,
    output logic              s1_sop,
    output logic              s1_eop,
    output logic [DATA_W-1:0] s1_data,
    output logic [PORT_W-1:0] s1_egr_port,
    output logic              s1_src_host,
    output logic [VF_W-1:0]   s1_src_vf
);

    // forwarding table, indexed by ingress port
    logic [PORT_W-1:0] fwd_tbl [NUM_PORTS];
    logic              fwd_wr;

    // decision for a sop word
    logic [PORT_W-1:0] sop_egr;
    logic              sop_host;
    logic [VF_W-1:0]   sop_vf;

    // held packet context
    logic [PORT_W-1:0] ctx_egr;
    logic              ctx_host;
    logic [VF_W-1:0]   ctx_vf;

    // ==============================
    // table writes
    // ==============================
    // 0x00..0x03, low bits pick the entry
    assign fwd_wr = reg_wr && (reg_addr[ADDR_W-1:PORT_W] == ADDR_FWD_BASE[ADDR_W-1:PORT_W]);

    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            fwd_tbl <= '{default: '0};
        end else if (fwd_wr) begin
            fwd_tbl[reg_addr[PORT_W-1:0]] <= reg_wdata[PORT_W-1:0];
        end
    end

    // ==============================
    // per packet decision
    // ==============================
    assign sop_egr  = fwd_tbl[in_port];
    assign sop_host = (in_port == PORT_HOST0) || (in_port == PORT_HOST1);
    // vf only meaningful for host sources
    assign sop_vf   = sop_host ? in_data[VF_W-1:0] : '0;

    // latch on sop, held until the next sop
    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            ctx_egr  <= '0;
            ctx_host <= 1'b0;
            ctx_vf   <= '0;
        end else if (in_valid && in_sop) begin
            ctx_egr  <= sop_egr;
            ctx_host <= sop_host;
            ctx_vf   <= sop_vf;
        end
    end

    // ==============================
    // stage 1 register
    // ==============================
    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // word plus context, sop word uses fresh lookup
    always_ff @(posedge tb) begin
        s1_sop      <= in_sop;
        s1_eop      <= in_eop;
        s1_data     <= in_data;
        s1_egr_port <= in_sop ? sop_egr  : ctx_egr;
        s1_src_host <= in_sop ? sop_host : ctx_host;
        s1_src_vf   <= in_sop ? sop_vf   : ctx_vf;
    end

endmodule

// ==== hash2qid/hash2qid.sv ====
`timescale 1ns/1ps

module hash2qid import smartnic_app_pkg::*; #(
    // base address of this block
    parameter logic [ADDR_W-1:0] REG_BASE = ADDR_H2Q0_BASE,
    // pf served, 0 or 1
    parameter int                PF_NUM   = 0
) (
    input  logic              tb,
    input  logic              arst_n,
    // config write strobe
    input  logic              reg_wr,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic [REG_W-1:0]  reg_wdata,
    // stage 1 in
    input  logic              s1_valid,
    input  logic              s1_sop,
    input  logic              s1_eop,
    input  logic [DATA_W-1:0] s1_data,
    input  logic [PORT_W-1:0] s1_egr_port,
    input  logic              s1_src_host,
    input  logic [VF_W-1:0]   s1_src_vf,
    input  logic              s1_src_pf,
    // stage 2 out
    output logic              s2_valid,
    output logic              s2_sop,
    output logic              s2_eop,
    output logic [DATA_W-1:0] s2_data,
    output logic [PORT_W-1:0] s2_egr_port,
    output logic              s2_rss_hit,
    output logic [QID_W-1:0]  s2_rss_entropy
);

    // queue base of the pf and per vf offsets
    logic [QID_W-1:0]     q_base;
    logic [QID_W-1:0]     vf_tbl [NUM_VF];

    logic                 blk_wr;
    logic [H2Q_OFS_W-1:0] ofs;
    logic [VF_W-1:0]      vf_wr_idx;

    logic                 hit;
    logic [QID_W-1:0]     entropy;

    // ==============================
    // register block
    // ==============================
    // upper address bits select the block
    assign blk_wr    = reg_wr &&
                       (reg_addr[ADDR_W-1:H2Q_OFS_W] == REG_BASE[ADDR_W-1:H2Q_OFS_W]);
    assign ofs       = reg_addr[H2Q_OFS_W-1:0];
    assign vf_wr_idx = VF_W'(ofs - H2Q_VF_TABLE_OFS);

    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            q_base <= '0;
            vf_tbl <= '{default: '0};
        end else if (blk_wr) begin
            if (ofs == H2Q_Q_CONFIG_OFS) begin
                q_base <= reg_wdata[QID_W-1:0];
            end else if ((ofs >= H2Q_VF_TABLE_OFS) &&
                         (ofs < H2Q_VF_TABLE_OFS + H2Q_OFS_W'(NUM_VF))) begin
                vf_tbl[vf_wr_idx] <= reg_wdata[QID_W-1:0];
            end
            // other offsets dropped
        end
    end

    // ==============================
    // rss entropy
    // ==============================
    // host source on this pf only
    assign hit     = s1_src_host && (s1_src_pf == 1'(PF_NUM));
    // wraps mod 4096
    assign entropy = hit ? (q_base + vf_tbl[s1_src_vf]) : '0;

    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid   <= 1'b0;
            s2_rss_hit <= 1'b0;
        end else begin
            s2_valid   <= s1_valid;
            s2_rss_hit <= s1_valid && hit;
        end
    end

    // word fields follow one clock behind
    always_ff @(posedge tb) begin
        s2_sop         <= s1_sop;
        s2_eop         <= s1_eop;
        s2_data        <= s1_data;
        s2_egr_port    <= s1_egr_port;
        s2_rss_entropy <= entropy;
    end

endmodule

// ==== src/egress_demux.sv ====
`timescale 1ns/1ps

module egress_demux import smartnic_app_pkg::*; (
    input  logic                 tb,
    input  logic                 arst_n,
    // config write strobe
    input  logic                 reg_wr,
    input  logic [ADDR_W-1:0]    reg_addr,
    input  logic [REG_W-1:0]     reg_wdata,
    // stage 2 in
    input  logic                 s2_valid,
    input  logic                 s2_sop,
    input  logic                 s2_eop,
    input  logic [DATA_W-1:0]    s2_data,
    input  logic [PORT_W-1:0]    s2_egr_port,
    input  logic [NUM_HOST-1:0]  s2_rss_hit,
    input  logic [QID_W-1:0]     s2_rss_entropy,
    input  logic                 s2_src_pf,
    // steered outputs
    output logic [NUM_PORTS-1:0] out_valid,
    output logic [NUM_HOST-1:0]  c2h_valid,
    output logic                 out_sop,
    output logic                 out_eop,
    output logic [DATA_W-1:0]    out_data,
    output logic [NUM_HOST-1:0]  rss_enable,
    output logic [QID_W-1:0]     rss_entropy0,
    output logic [QID_W-1:0]     rss_entropy1
);

    // bit n set sends host n traffic to c2h
    logic [NUM_HOST-1:0]  demux_sel;

    logic                 sop_c2h;
    logic                 ctx_c2h;
    logic                 cur_c2h;
    logic [NUM_PORTS-1:0] port_oh;
    logic                 rss_ok;
    logic                 host_idx;

    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            demux_sel <= '0;
        end else if (reg_wr && (reg_addr == ADDR_DEMUX_SEL)) begin
            demux_sel <= reg_wdata[NUM_HOST-1:0];
        end
    end

    // ==============================
    // steering
    // ==============================
    // select sampled on sop, held for the packet
    assign sop_c2h  = (s2_egr_port == PORT_HOST0) ? demux_sel[0] :
                      (s2_egr_port == PORT_HOST1) ? demux_sel[1] : 1'b0;
    assign cur_c2h  = s2_sop ? sop_c2h : ctx_c2h;
    assign host_idx = s2_egr_port[0];

    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            ctx_c2h <= 1'b0;
        end else if (s2_valid && s2_sop) begin
            ctx_c2h <= sop_c2h;
        end
    end

    // host egress loops back to the mac of same index
    always_comb begin
        case (s2_egr_port)
            PORT_CMAC0: port_oh = 4'b0001;
            PORT_CMAC1: port_oh = 4'b0010;
            PORT_HOST0: port_oh = cur_c2h ? 4'b0100 : 4'b0001;
            default:    port_oh = cur_c2h ? 4'b1000 : 4'b0010;
        endcase
    end

    // hit must come from the source pf instance
    assign rss_ok = s2_valid && cur_c2h && s2_rss_hit[s2_src_pf];

    // ==============================
    // output stage
    // ==============================
    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= '0;
            rss_enable <= '0;
        end else begin
            out_valid  <= s2_valid ? port_oh : '0;
            rss_enable <= rss_ok ? (2'b01 << host_idx) : 2'b00;
        end
    end

    // entropy only on the chosen host index
    always_ff @(posedge tb) begin
        out_sop      <= s2_sop;
        out_eop      <= s2_eop;
        out_data     <= s2_data;
        rss_entropy0 <= (rss_ok && !host_idx) ? s2_rss_entropy : '0;
        rss_entropy1 <= (rss_ok && host_idx)  ? s2_rss_entropy : '0;
    end

    // host ports are the c2h strobes
    assign c2h_valid = out_valid[NUM_PORTS-1:NUM_PORTS-NUM_HOST];

endmodule

// ==== src/smartnic_app_datapath.sv ====
`timescale 1ns/1ps

module smartnic_app_datapath import smartnic_app_pkg::*; (
    input  logic                 tb,
    input  logic                 arst_n,
    input  logic                 reg_wr,
    input  logic [ADDR_W-1:0]    reg_addr,
    input  logic [REG_W-1:0]     reg_wdata,
    input  logic                 in_valid,
    input  logic                 in_sop,
    input  logic                 in_eop,
    input  logic [PORT_W-1:0]    in_port,
    input  logic [DATA_W-1:0]    in_data,
    output logic [NUM_PORTS-1:0] out_valid,
    output logic [NUM_HOST-1:0]  c2h_valid,
    output logic                 out_sop,
    output logic                 out_eop,
    output logic [DATA_W-1:0]    out_data,
    output logic [NUM_HOST-1:0]  rss_enable,
    output logic [QID_W-1:0]     rss_entropy0,
    output logic [QID_W-1:0]     rss_entropy1
);

    // stage 1
    logic              s1_valid, s1_sop, s1_eop, s1_src_host, s1_src_pf;
    logic [DATA_W-1:0] s1_data;
    logic [PORT_W-1:0] s1_egr_port;
    logic [VF_W-1:0]   s1_src_vf;

    // stage 2, word from the pf0 instance
    logic                s2_valid, s2_sop, s2_eop, s2_src_pf;
    logic [DATA_W-1:0]   s2_data;
    logic [PORT_W-1:0]   s2_egr_port;
    logic [NUM_HOST-1:0] s2_rss_hit;
    logic [QID_W-1:0]    s2_rss_entropy;
    logic [QID_W-1:0]    h2q0_entropy, h2q1_entropy;

    // source pf rides along, latched on sop
    logic pf_ctx;

    always_ff @(posedge tb or negedge arst_n) begin
        if (!arst_n) begin
            pf_ctx <= 1'b0;
        end else if (in_valid && in_sop) begin
            pf_ctx <= in_port[0];
        end
    end

    always_ff @(posedge tb) begin
        s1_src_pf <= in_sop ? in_port[0] : pf_ctx;
        s2_src_pf <= s1_src_pf;
    end

    p4_lookup u_lookup (
        .tb, .arst_n, .reg_wr, .reg_addr, .reg_wdata,
        .in_valid, .in_sop, .in_eop, .in_port, .in_data,
        .s1_valid, .s1_sop, .s1_eop, .s1_data, .s1_egr_port, .s1_src_host, .s1_src_vf
    );

    hash2qid #(.REG_BASE(ADDR_H2Q0_BASE), .PF_NUM(0)) u_h2q0 (
        .tb, .arst_n, .reg_wr, .reg_addr, .reg_wdata,
        .s1_valid, .s1_sop, .s1_eop, .s1_data, .s1_egr_port, .s1_src_host, .s1_src_vf,
        .s1_src_pf, .s2_valid, .s2_sop, .s2_eop, .s2_data, .s2_egr_port,
        .s2_rss_hit (s2_rss_hit[0]), .s2_rss_entropy (h2q0_entropy)
    );

    // metadata only
    hash2qid #(.REG_BASE(ADDR_H2Q1_BASE), .PF_NUM(1)) u_h2q1 (
        .tb, .arst_n, .reg_wr, .reg_addr, .reg_wdata,
        .s1_valid, .s1_sop, .s1_eop, .s1_data, .s1_egr_port, .s1_src_host, .s1_src_vf,
        .s1_src_pf, .s2_valid (), .s2_sop (), .s2_eop (), .s2_data (), .s2_egr_port (),
        .s2_rss_hit (s2_rss_hit[1]), .s2_rss_entropy (h2q1_entropy)
    );

    // entropy of the source pf
    assign s2_rss_entropy = s2_src_pf ? h2q1_entropy : h2q0_entropy;

    egress_demux u_demux (
        .tb, .arst_n, .reg_wr, .reg_addr, .reg_wdata,
        .s2_valid, .s2_sop, .s2_eop, .s2_data, .s2_egr_port,
        .s2_rss_hit, .s2_rss_entropy, .s2_src_pf,
        .out_valid, .c2h_valid, .out_sop, .out_eop, .out_data,
        .rss_enable, .rss_entropy0, .rss_entropy1
    );

endmodule

// ==== tb/tb_smartnic_app_datapath.sv ====
`timescale 1ns/1ps

module tb_smartnic_app_datapath;

    localparam string STIM_FILE = "tb/stim_smartnic_app.txt";

    logic        tb = 1'b0;
    logic        arst_n;
    logic        reg_wr;
    logic [7:0]  reg_addr;
    logic [15:0] reg_wdata;
    logic        in_valid;
    logic        in_sop;
    logic        in_eop;
    logic [1:0]  in_port;
    logic [63:0] in_data;
    logic [3:0]  out_valid;
    logic [1:0]  c2h_valid;
    logic        out_sop;
    logic        out_eop;
    logic [63:0] out_data;
    logic [1:0]  rss_enable;
    logic [11:0] rss_entropy0;
    logic [11:0] rss_entropy1;

    // expected output per driven cycle, oldest first
    logic [3:0]  q_out[$];
    logic [1:0]  q_c2h[$];
    logic        q_sop[$];
    logic        q_eop[$];
    logic [63:0] q_data[$];
    logic [1:0]  q_rss[$];
    logic [11:0] q_ent0[$];
    logic [11:0] q_ent1[$];

    int seed = 32'h587f_179f;
    int num_words = 0;
    int num_records = 0;
    int limit_cycles = 0;
    int cycle_cnt = 0;

    smartnic_app_datapath u_dut (
        .tb, .arst_n, .reg_wr, .reg_addr, .reg_wdata,
        .in_valid, .in_sop, .in_eop, .in_port, .in_data,
        .out_valid, .c2h_valid, .out_sop, .out_eop, .out_data,
        .rss_enable, .rss_entropy0, .rss_entropy1
    );

    // 8 ns period
    always #4 tb = ~tb;

    // ==============================
    // failure and compare
    // ==============================
    task abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // run limit, set once the stimulus file is sized
    always @(posedge tb) begin
        cycle_cnt = cycle_cnt + 1;
        if (limit_cycles != 0 && cycle_cnt >= limit_cycles) begin
            $display("run did not finish within %0d cycles", limit_cycles);
            abort_run();
        end
    end

    // ==============================
    // expected queue
    // ==============================
    task automatic push_expect(input logic [3:0] e_out, input logic [1:0] e_c2h,
                               input logic e_sop, input logic e_eop,
                               input logic [63:0] e_data, input logic [1:0] e_rss,
                               input logic [11:0] e_ent0, input logic [11:0] e_ent1);
        q_out.push_back(e_out);
        q_c2h.push_back(e_c2h);
        q_sop.push_back(e_sop);
        q_eop.push_back(e_eop);
        q_data.push_back(e_data);
        q_rss.push_back(e_rss);
        q_ent0.push_back(e_ent0);
        q_ent1.push_back(e_ent1);
    endtask

    // outputs of the word driven three clocks ago
    task automatic check_outputs();
        logic [3:0]  e_out;
        logic        e_sop;
        logic        e_eop;
        logic [63:0] e_data;
        e_out  = q_out.pop_front();
        e_sop  = q_sop.pop_front();
        e_eop  = q_eop.pop_front();
        e_data = q_data.pop_front();
        compare_value("out_valid", out_valid, e_out);
        compare_value("c2h_valid", c2h_valid, q_c2h.pop_front());
        compare_value("rss_enable", rss_enable, q_rss.pop_front());
        compare_value("rss_entropy0", rss_entropy0, q_ent0.pop_front());
        compare_value("rss_entropy1", rss_entropy1, q_ent1.pop_front());
        // word fields only matter with a strobe
        if (e_out != 4'b0000) begin
            compare_value("out_sop", out_sop, e_sop);
            compare_value("out_eop", out_eop, e_eop);
            compare_value("out_data", out_data, e_data);
        end
    endtask

    // ==============================
    // drive helpers
    // ==============================
    // outputs are stable at the falling edge
    task automatic next_cycle();
        @(negedge tb);
        if (q_out.size() == 3) begin
            check_outputs();
        end
    endtask

    task automatic drive_inputs(input logic wr, input logic [7:0] addr,
                                input logic [15:0] wdata, input logic valid,
                                input logic sop, input logic eop,
                                input logic [1:0] port, input logic [63:0] data);
        reg_wr    = wr;
        reg_addr  = addr;
        reg_wdata = wdata;
        in_valid  = valid;
        in_sop    = sop;
        in_eop    = eop;
        in_port   = port;
        in_data   = data;
    endtask

    task automatic idle_cycle();
        next_cycle();
        drive_inputs(1'b0, 8'h00, 16'h0000, 1'b0, 1'b0, 1'b0, 2'd0, 64'd0);
        push_expect(4'b0000, 2'b00, 1'b0, 1'b0, 64'd0, 2'b00, 12'd0, 12'd0);
    endtask

    // earlier packets leave before the config changes
    task automatic write_reg(input logic [7:0] addr, input logic [15:0] wdata);
        repeat (3) idle_cycle();
        next_cycle();
        drive_inputs(1'b1, addr, wdata, 1'b0, 1'b0, 1'b0, 2'd0, 64'd0);
        push_expect(4'b0000, 2'b00, 1'b0, 1'b0, 64'd0, 2'b00, 12'd0, 12'd0);
    endtask

    task automatic send_packet(input logic [1:0] port, input logic [1:0] vf, input int cnt,
                               input logic [63:0] data0, input logic to_c2h,
                               input logic idx, input logic rss_en,
                               input logic [11:0] ent);
        logic [3:0]  e_out;
        logic [1:0]  e_c2h;
        logic [1:0]  e_rss;
        logic [63:0] data;
        // host strobes sit above the two mac strobes
        e_out = to_c2h ? (4'b0100 << idx) : (4'b0001 << idx);
        e_c2h = to_c2h ? (2'b01 << idx) : 2'b00;
        e_rss = rss_en ? (2'b01 << idx) : 2'b00;
        for (int w = 0; w < cnt; w++) begin
            // sop word carries the vf in its low bits
            data = (w == 0) ? {data0[63:2], vf} : {$random(seed), $random(seed)};
            next_cycle();
            drive_inputs(1'b0, 8'h00, 16'h0000, 1'b1, w == 0, w == cnt - 1, port, data);
            push_expect(e_out, e_c2h, w == 0, w == cnt - 1, data, e_rss,
                        (rss_en && !idx) ? ent : 12'd0, (rss_en && idx) ? ent : 12'd0);
        end
    endtask

    // ==============================
    // stimulus file
    // ==============================
    // first pass only sizes the run, second pass drives it
    task automatic run_file(input bit execute);
        int                 fd;
        int                 r;
        int                 port;
        int                 vf;
        int                 cnt;
        int                 idx;
        int                 rss_en;
        logic [63:0]        tag;
        logic [63:0]        kind;
        logic [63:0]        data0;
        logic [15:0]        addr;
        logic [15:0]        wdata;
        logic [15:0]        ent;
        logic [8*128-1:0]   line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            abort_run();
        end
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tag);
            if (r == 1) begin
                if (tag == "#") begin
                    r = $fgets(line, fd);
                end else if (tag == "W") begin
                    r = $fscanf(fd, "%h %h", addr, wdata);
                    if (r != 2) begin
                        $display("register write record is incomplete");
                        abort_run();
                    end
                    if (execute) begin
                        write_reg(addr[7:0], wdata);
                    end else begin
                        num_records++;
                    end
                end else if (tag == "P") begin
                    r = $fscanf(fd, "%d %d %d %h %s %d %d %h",
                                port, vf, cnt, data0, kind, idx, rss_en, ent);
                    if (r != 8 || (kind != "mac" && kind != "c2h")) begin
                        $display("packet record is incomplete or has a bad output kind");
                        abort_run();
                    end
                    if (execute) begin
                        send_packet(port[1:0], vf[1:0], cnt, data0, kind == "c2h",
                                    idx[0], rss_en[0], ent[11:0]);
                    end else begin
                        num_records++;
                        num_words += cnt;
                    end
                end else begin
                    $display("unknown record type in the stimulus file");
                    abort_run();
                end
            end
        end
        $fclose(fd);
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        arst_n = 1'b0;
        drive_inputs(1'b0, 8'h00, 16'h0000, 1'b0, 1'b0, 1'b0, 2'd0, 64'd0);
        run_file(1'b0);
        // margin covers reset and the final drain
        limit_cycles = num_words + 20 * num_records + 20;
        repeat (3) @(negedge tb);
        arst_n = 1'b1;
        // outputs must stay quiet before any traffic
        repeat (4) idle_cycle();
        run_file(1'b1);
        repeat (4) idle_cycle();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== smartnic_app_datapath.f ====
common/smartnic_app_pkg.sv
src/p4_lookup.sv
hash2qid/hash2qid.sv
src/egress_demux.sv
src/smartnic_app_datapath.sv
tb/tb_smartnic_app_datapath.sv

// ==== tb/stim_smartnic_app.txt ====
# W addr data : register write, both hex
# P port vf words data0(hex) kind(mac|c2h) index rss_en entropy(hex)
W 00 0000
W 01 0001
P 0 0 3 1111222233334440 mac 0 0 000
P 1 0 2 5555666677778880 mac 1 0 000
W 00 0001
W 01 0000
P 0 0 1 99990000aaaa0000 mac 1 0 000
P 1 0 4 bbbb0000cccc0000 mac 0 0 000
W 02 0002
W 03 0003
W 10 0003
W 20 0001
W 21 0010
W 22 0020
W 23 0030
W 24 0040
W 30 0010
W 31 0100
W 32 0200
W 33 0300
W 34 0400
P 2 1 3 0123456789abcde0 c2h 0 1 021
P 3 2 2 fedcba9876543210 c2h 1 1 310
P 2 3 2 1000000000000000 c2h 0 1 041
P 3 0 1 2000000000000000 c2h 1 1 110
P 0 0 2 3000000000000000 mac 1 0 000
P 2 0 1 4000000000000000 c2h 0 1 011
W 02 0003
P 2 2 2 5000000000000000 c2h 1 1 031
W 00 0002
P 0 1 2 6000000000000000 c2h 0 0 000
W 02 0002
W 10 0000
P 2 1 2 7000000000000000 mac 0 0 000
P 3 1 1 8000000000000000 mac 1 0 000
W 20 0100
W 10 0001
P 2 1 2 9000000000000000 c2h 0 1 120
P 3 3 1 a000000000000000 mac 1 0 000
W 10 0003
W 30 0020
W 31 0ff0
P 3 0 1 b000000000000000 c2h 1 1 010
